//--- all.f
hdl/soc_pkg.sv
hdl/dual_port_ram.sv
hdl/host_packet_rx.sv
hdl/host_ctrl.sv
hdl/dmem_switch.sv
hdl/wb_cpu_port.sv
hdl/sc1_fabric_top.sv
tb/tb_top.sv

//--- hdl/dmem_switch.sv
`timescale 1ns/1ps

module dmem_switch (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         dmem_owner,
  input  soc_pkg::mem_wr_t             host_dmem_wr,
  input  soc_pkg::mem_wr_t             cpu_dmem_wr,
  input  logic [soc_pkg::page_bits-1:0] cpu_dmem_raddr,
  output logic [soc_pkg::data_w-1:0]    cpu_dmem_rdata
);

  import soc_pkg::*;

  mem_wr_t           ram_wr;
  logic [data_w-1:0] ram_rdata;
  logic              rd_owner_q;

  // only the current owner reaches the write port
  assign ram_wr = (dmem_owner == owner_cpu) ? cpu_dmem_wr : host_dmem_wr;

  // owner at the time of the read lines up with ram_rdata
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_owner_q <= owner_host;
    end
    else
    begin
      rd_owner_q <= dmem_owner;
    end
  end

  assign cpu_dmem_rdata = (rd_owner_q == owner_cpu) ? ram_rdata : '0;

  dual_port_ram #(
    .data_bits (data_w),
    .addr_bits (page_bits)
  ) dmem_ram (
    .clk     (clk),
    .wr_en   (ram_wr.en),
    .wr_addr (ram_wr.offset),
    .wr_data (ram_wr.data),
    .rd_addr (cpu_dmem_raddr),
    .rd_data (ram_rdata)
  );

  owner_write_only: assert property (@(posedge clk) disable iff (!arst_n)
    ram_wr.en |-> ((dmem_owner == owner_cpu && cpu_dmem_wr.en) ||
                   (dmem_owner == owner_host && host_dmem_wr.en)));

endmodule

//--- hdl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int data_bits = 32,
  parameter int addr_bits = 12
) (
  input  logic                 clk,
  input  logic                 wr_en,
  input  logic [addr_bits-1:0] wr_addr,
  input  logic [data_bits-1:0] wr_data,
  input  logic [addr_bits-1:0] rd_addr,
  output logic [data_bits-1:0] rd_data
);

  logic [data_bits-1:0] mem [2**addr_bits];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read before write on a shared address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/host_ctrl.sv
`timescale 1ns/1ps

module host_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::host_wr_t host_wr,
  output soc_pkg::mem_wr_t  imem_wr,
  output soc_pkg::mem_wr_t  host_dmem_wr,
  output logic              cpu_hold,
  output logic              cpu_resume,
  output logic              dmem_owner
);

  import soc_pkg::*;

  bus_addr_u            wr_addr;
  logic [page_w-1:0]    wr_page;
  logic                 sys_we_q;
  logic [reg_idx_w-1:0] sys_idx_q;
  logic                 sys_bit_q;

  assign wr_addr = host_wr.addr;
  assign wr_page = page_of(host_wr.addr);

  // first stage registers one routed write per target
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      imem_wr      <= '0;
      host_dmem_wr <= '0;
      sys_we_q     <= 1'b0;
      sys_idx_q    <= '0;
      sys_bit_q    <= 1'b0;
    end
    else
    begin
      imem_wr.en          <= host_wr.valid && wr_page == page_imem;
      imem_wr.offset      <= wr_addr.mem.offset;
      imem_wr.data        <= host_wr.data;
      host_dmem_wr.en     <= host_wr.valid && wr_page == page_dmem;
      host_dmem_wr.offset <= wr_addr.mem.offset;
      host_dmem_wr.data   <= host_wr.data;
      sys_we_q            <= host_wr.valid && wr_page == page_sys;
      sys_idx_q           <= wr_addr.regs.idx;
      sys_bit_q           <= host_wr.data[0];
    end
  end

  // system registers keep bit 0 of the written word
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cpu_hold   <= 1'b0;
      cpu_resume <= 1'b0;
      dmem_owner <= owner_host;
    end
    else if (sys_we_q)
    begin
      case (sys_idx_q)
        sys_hold_idx:   cpu_hold   <= sys_bit_q;
        sys_resume_idx: cpu_resume <= sys_bit_q;
        sys_owner_idx:  dmem_owner <= sys_bit_q;
        default:        ;
      endcase
    end
  end

  one_target: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({imem_wr.en, host_dmem_wr.en, sys_we_q}));

endmodule

//--- hdl/host_packet_rx.sv
`timescale 1ns/1ps

module host_packet_rx (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              host_rx_valid,
  input  logic [7:0]        host_rx_byte,
  output soc_pkg::host_wr_t host_wr
);

  import soc_pkg::*;

  logic                     valid_q;
  logic                     byte_stb;
  logic [3:0]               byte_cnt;
  logic                     wr_pend;
  logic [addr_w+data_w-1:0] shift_q;

  // one strobe per byte on the rising edge of valid
  assign byte_stb = host_rx_valid & ~valid_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q  <= 1'b0;
      byte_cnt <= 4'd0;
      wr_pend  <= 1'b0;
    end
    else
    begin
      valid_q <= host_rx_valid;
      wr_pend <= 1'b0;
      if (byte_stb)
      begin
        case (byte_cnt)
          4'd0:
          begin
            // wait here for a start byte
            if (host_rx_byte == pkt_start)
            begin
              byte_cnt <= 4'd1;
            end
          end
          4'(pkt_len - 1):
          begin
            byte_cnt <= 4'd0;
            wr_pend  <= (host_rx_byte == pkt_end);
          end
          default:
          begin
            byte_cnt <= byte_cnt + 4'd1;
          end
        endcase
      end
    end
  end

  // address and data bytes arrive msb first
  // only the low addr_w bits of the address survive the shift
  always_ff @(posedge clk)
  begin
    if (byte_stb && byte_cnt != 4'd0 && byte_cnt != 4'(pkt_len - 1))
    begin
      shift_q <= {shift_q[addr_w+data_w-9:0], host_rx_byte};
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      host_wr <= '0;
    end
    else
    begin
      host_wr.valid <= wr_pend;
      if (wr_pend)
      begin
        host_wr.addr <= shift_q[addr_w+data_w-1:data_w];
        host_wr.data <= shift_q[data_w-1:0];
      end
    end
  end

  byte_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    byte_cnt < 4'(pkt_len));

endmodule

//--- hdl/sc1_fabric_top.sv
`timescale 1ns/1ps

module sc1_fabric_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          host_rx_valid,
  input  logic [7:0]                    host_rx_byte,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [soc_pkg::addr_w-1:0]    wb_adr,
  input  logic [soc_pkg::data_w-1:0]    wb_dat_w,
  output logic [soc_pkg::data_w-1:0]    wb_dat_r,
  output logic                          wb_ack,
  input  logic [soc_pkg::page_bits-1:0] fetch_addr,
  output logic [soc_pkg::data_w-1:0]    fetch_data,
  output logic                          cpu_hold,
  output logic                          cpu_resume,
  output logic [soc_pkg::led_w-1:0]     led
);

  import soc_pkg::*;

  host_wr_t             host_wr;
  mem_wr_t              imem_wr;
  mem_wr_t              host_dmem_wr;
  mem_wr_t              cpu_dmem_wr;
  logic                 dmem_owner;
  logic [page_bits-1:0] cpu_dmem_raddr;
  logic [data_w-1:0]    cpu_dmem_rdata;

  host_packet_rx host_rx0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .host_rx_valid (host_rx_valid),
    .host_rx_byte  (host_rx_byte),
    .host_wr       (host_wr)
  );

  host_ctrl host_ctrl0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .host_wr      (host_wr),
    .imem_wr      (imem_wr),
    .host_dmem_wr (host_dmem_wr),
    .cpu_hold     (cpu_hold),
    .cpu_resume   (cpu_resume),
    .dmem_owner   (dmem_owner)
  );

  // code memory written by the host and read by CPU fetch
  dual_port_ram #(
    .data_bits (data_w),
    .addr_bits (page_bits)
  ) imem_ram (
    .clk     (clk),
    .wr_en   (imem_wr.en),
    .wr_addr (imem_wr.offset),
    .wr_data (imem_wr.data),
    .rd_addr (fetch_addr),
    .rd_data (fetch_data)
  );

  dmem_switch dmem_switch0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .dmem_owner     (dmem_owner),
    .host_dmem_wr   (host_dmem_wr),
    .cpu_dmem_wr    (cpu_dmem_wr),
    .cpu_dmem_raddr (cpu_dmem_raddr),
    .cpu_dmem_rdata (cpu_dmem_rdata)
  );

  wb_cpu_port wb_port0 (
    .clk            (clk),
    .arst_n         (arst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .cpu_dmem_wr    (cpu_dmem_wr),
    .cpu_dmem_raddr (cpu_dmem_raddr),
    .cpu_dmem_rdata (cpu_dmem_rdata),
    .led            (led)
  );

endmodule

//--- hdl/soc_pkg.sv
package soc_pkg;

  // bus geometry
  localparam int addr_w    = 17;
  localparam int data_w    = 32;
  localparam int page_bits = 12;
  localparam int page_w    = addr_w - page_bits;
  localparam int reg_idx_w = 4;

  // page map in the upper address bits
  localparam logic [page_w-1:0] page_dmem  = 5'd0;
  localparam logic [page_w-1:0] page_reg_r = 5'd2;
  localparam logic [page_w-1:0] page_reg_w = 5'd3;
  localparam logic [page_w-1:0] page_imem  = 5'd4;
  localparam logic [page_w-1:0] page_sys   = 5'd5;

  // I/O write page
  localparam logic [reg_idx_w-1:0] io_led_idx = 4'd4;
  localparam int led_w = 10;

  // system registers written by the host only
  localparam logic [reg_idx_w-1:0] sys_hold_idx   = 4'd0;
  localparam logic [reg_idx_w-1:0] sys_resume_idx = 4'd1;
  localparam logic [reg_idx_w-1:0] sys_owner_idx  = 4'd2;

  // data memory owner
  localparam logic owner_host = 1'b0;
  localparam logic owner_cpu  = 1'b1;

  // host packet framing
  localparam logic [7:0] pkt_start = 8'hAA;
  localparam logic [7:0] pkt_end   = 8'h55;
  localparam int pkt_len = 10;

  typedef struct packed {
    logic [page_w-1:0]    page;
    logic [page_bits-1:0] offset;
  } mem_view_t;

  typedef struct packed {
    logic [page_w-1:0]              page;
    logic [page_bits-reg_idx_w-1:0] unused;
    logic [reg_idx_w-1:0]           idx;
  } reg_view_t;

  // one address word seen as memory offset or as register index
  typedef union packed {
    mem_view_t mem;
    reg_view_t regs;
  } bus_addr_u;

  // decoded write into a RAM
  typedef struct packed {
    logic                 en;
    logic [page_bits-1:0] offset;
    logic [data_w-1:0]    data;
  } mem_wr_t;

  // framed write from the host byte stream
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } host_wr_t;

  // page number of a bus address
  function automatic logic [page_w-1:0] page_of(input logic [addr_w-1:0] addr);
    return addr[addr_w-1 -: page_w];
  endfunction

endpackage

//--- hdl/wb_cpu_port.sv
`timescale 1ns/1ps

module wb_cpu_port (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [soc_pkg::addr_w-1:0]    wb_adr,
  input  logic [soc_pkg::data_w-1:0]    wb_dat_w,
  output logic [soc_pkg::data_w-1:0]    wb_dat_r,
  output logic                          wb_ack,
  output soc_pkg::mem_wr_t              cpu_dmem_wr,
  output logic [soc_pkg::page_bits-1:0] cpu_dmem_raddr,
  input  logic [soc_pkg::data_w-1:0]    cpu_dmem_rdata,
  output logic [soc_pkg::led_w-1:0]     led
);

  import soc_pkg::*;

  bus_addr_u         req_addr;
  logic [page_w-1:0] req_page;
  logic [page_w-1:0] page_q;
  logic              req;
  logic              led_we;

  // a request is live until it is acked
  assign req      = wb_cyc & wb_stb & ~wb_ack;
  assign req_addr = wb_adr;
  assign req_page = page_of(wb_adr);

  assign cpu_dmem_wr.en     = req && wb_we && req_page == page_dmem;
  assign cpu_dmem_wr.offset = req_addr.mem.offset;
  assign cpu_dmem_wr.data   = wb_dat_w;
  assign cpu_dmem_raddr     = req_addr.mem.offset;

  // sys page writes fall through here as those registers are host only
  assign led_we = req && wb_we && req_page == page_reg_w && req_addr.regs.idx == io_led_idx;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_ack <= 1'b0;
      page_q <= '0;
      led    <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req)
      begin
        page_q <= req_page;
      end
      if (led_we)
      begin
        led <= wb_dat_w[led_w-1:0];
      end
    end
  end

  // read page 2 and the unmapped pages return zero
  assign wb_dat_r = (page_q == page_dmem) ? cpu_dmem_rdata : '0;

  single_ack: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack);

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q -x -F '>>> PASS'; then
  exit 0
else
  exit 1
fi

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  // operation kinds
  localparam int k_pkt     = 0;
  localparam int k_bad_pkt = 1;
  localparam int k_wb_wr   = 2;
  localparam int k_wb_rd   = 3;
  localparam int k_fetch   = 4;
  localparam int k_check   = 5;

  // outputs selected by the addr column of a check
  localparam int chk_led    = 0;
  localparam int chk_hold   = 1;
  localparam int chk_resume = 2;

  localparam int max_ops = 48;

  logic        clk;
  logic        arst_n;
  logic        host_rx_valid;
  logic [7:0]  host_rx_byte;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [16:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [11:0] fetch_addr;
  logic [31:0] fetch_data;
  logic        cpu_hold;
  logic        cpu_resume;
  logic [9:0]  led;

  int          op_kind [max_ops];
  logic [16:0] op_addr [max_ops];
  logic [31:0] op_data [max_ops];
  logic [31:0] op_exp  [max_ops];
  string       op_name [max_ops];
  int          n_ops;
  logic [31:0] rnd [8];
  int          cycle_cnt;
  int          cycle_limit;

  sc1_fabric_top dut0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .host_rx_valid (host_rx_valid),
    .host_rx_byte  (host_rx_byte),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .fetch_addr    (fetch_addr),
    .fetch_data    (fetch_data),
    .cpu_hold      (cpu_hold),
    .cpu_resume    (cpu_resume),
    .led           (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("run stopped after %0d cycles, a test never finished", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // page number above a 12-bit offset or register index
  function automatic logic [16:0] addr_of(input int page, input int off);
    return 17'(page * 4096 + off);
  endfunction

  function automatic void add_op(input int kind, input logic [16:0] addr,
                                 input logic [31:0] data, input logic [31:0] exp,
                                 input string name);
    op_kind[n_ops] = kind;
    op_addr[n_ops] = addr;
    op_data[n_ops] = data;
    op_exp[n_ops]  = exp;
    op_name[n_ops] = name;
    n_ops = n_ops + 1;
  endfunction

  function automatic int cycles_of(input int kind);
    if (kind == k_pkt || kind == k_bad_pkt)
      return 49;
    else if (kind == k_wb_wr || kind == k_wb_rd)
      return 6;
    else
      return 2;
  endfunction

  function automatic string problem_text(input int status);
    if (status == 2)
      return "no ack came back for the request";
    else if (status == 3)
      return "ack came later than one cycle after the request";
    else
      return "ack stayed high for more than one cycle";
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input logic [7:0] b);
    host_rx_byte  = b;
    host_rx_valid = 1'b1;
    step();
    step();
    host_rx_valid = 1'b0;
    step();
    step();
  endtask

  task automatic send_packet(input logic [7:0] start_b, input logic [16:0] addr,
                             input logic [31:0] data, input logic [7:0] end_b);
    logic [31:0] a32;
    int k;
    a32 = {15'd0, addr};
    send_byte(start_b);
    for (k = 3; k >= 0; k--)
      send_byte(a32[k*8 +: 8]);
    for (k = 3; k >= 0; k--)
      send_byte(data[k*8 +: 8]);
    send_byte(end_b);
    repeat (8) step();
  endtask

  task automatic wb_access(input logic we, input logic [16:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output int status);
    int waited;
    waited   = 0;
    status   = 0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = data;
    step();
    while (!wb_ack && waited < 4)
    begin
      step();
      waited++;
    end
    if (!wb_ack)
      status = 2;
    else if (waited > 0)
      status = 3;
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    step();
    if (status == 0 && wb_ack)
      status = 4;
  endtask

  task automatic run_op(input int i, output logic [31:0] got, output int status);
    got    = '0;
    status = 0;
    case (op_kind[i])
      k_pkt:     send_packet(8'hAA, op_addr[i], op_data[i], 8'h55);
      // corrupt packets carry their framing bytes in the exp column
      k_bad_pkt: send_packet(op_exp[i][15:8], op_addr[i], op_data[i], op_exp[i][7:0]);
      k_wb_wr:   wb_access(1'b1, op_addr[i], op_data[i], got, status);
      k_wb_rd:   wb_access(1'b0, op_addr[i], op_data[i], got, status);
      k_fetch:
      begin
        fetch_addr = op_addr[i][11:0];
        step();
        got = fetch_data;
      end
      default:
      begin
        if (op_addr[i] == 17'(chk_led))
          got = {22'd0, led};
        else if (op_addr[i] == 17'(chk_hold))
          got = {31'd0, cpu_hold};
        else
          got = {31'd0, cpu_resume};
      end
    endcase
    if (status == 0 && (op_kind[i] == k_wb_rd || op_kind[i] >= k_fetch) && got !== op_exp[i])
      status = 1;
  endtask

  initial
  begin
    logic [31:0] got;
    int status;
    int i;
    int n_pass;
    int n_fail;

    host_rx_valid = 1'b0;
    host_rx_byte  = 8'd0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    fetch_addr    = '0;
    arst_n        = 1'b0;
    cycle_cnt     = 0;
    n_ops         = 0;
    n_pass        = 0;
    n_fail        = 0;

    void'($urandom(32'h922e9f63));
    for (i = 0; i < 8; i++)
      rnd[i] = $urandom();

    // reset values
    add_op(k_check, 17'(chk_led), 0, 0, "reset_led");
    add_op(k_check, 17'(chk_hold), 0, 0, "reset_hold");
    add_op(k_check, 17'(chk_resume), 0, 0, "reset_resume");
    add_op(k_wb_rd, addr_of(0, 0), 0, 0, "reset_dmem_read");
    // system registers and bad framing
    add_op(k_pkt, addr_of(5, 0), 1, 0, "host_hold_set");
    add_op(k_check, 17'(chk_hold), 0, 1, "hold_is_1");
    add_op(k_pkt, addr_of(5, 1), 1, 0, "host_resume_set");
    add_op(k_check, 17'(chk_resume), 0, 1, "resume_is_1");
    add_op(k_pkt, addr_of(5, 0), 32'hFFFF_FFFE, 0, "host_hold_clear");
    add_op(k_check, 17'(chk_hold), 0, 0, "hold_is_0");
    add_op(k_bad_pkt, addr_of(5, 0), 1, 32'h5A55, "bad_start_hold");
    add_op(k_check, 17'(chk_hold), 0, 0, "hold_kept_bad_start");
    add_op(k_bad_pkt, addr_of(5, 0), 1, 32'hAAA5, "bad_end_hold");
    add_op(k_check, 17'(chk_hold), 0, 0, "hold_kept_bad_end");
    add_op(k_bad_pkt, addr_of(5, 1), 0, 32'hAA5A, "bad_end_resume");
    add_op(k_check, 17'(chk_resume), 0, 1, "resume_kept_bad_end");
    // code memory
    add_op(k_pkt, addr_of(4, 3), rnd[0], 0, "imem_wr_3");
    add_op(k_pkt, addr_of(4, 100), rnd[1], 0, "imem_wr_100");
    add_op(k_pkt, addr_of(4, 4095), rnd[2], 0, "imem_wr_4095");
    add_op(k_fetch, 17'(3), 0, rnd[0], "fetch_3");
    add_op(k_fetch, 17'(100), 0, rnd[1], "fetch_100");
    add_op(k_fetch, 17'(4095), 0, rnd[2], "fetch_4095");
    // data memory ownership
    add_op(k_pkt, addr_of(0, 7), rnd[3], 0, "host_dmem_wr_7");
    add_op(k_wb_rd, addr_of(0, 7), 0, 0, "cpu_read_host_owned");
    add_op(k_pkt, addr_of(5, 2), 1, 0, "owner_to_cpu");
    add_op(k_wb_rd, addr_of(0, 7), 0, rnd[3], "cpu_read_cpu_owned");
    add_op(k_wb_wr, addr_of(0, 9), rnd[4], 0, "cpu_dmem_wr_9");
    add_op(k_wb_rd, addr_of(0, 9), 0, rnd[4], "cpu_read_back_9");
    add_op(k_pkt, addr_of(0, 9), rnd[5], 0, "host_dmem_wr_ignored");
    add_op(k_wb_rd, addr_of(0, 9), 0, rnd[4], "cpu_read_still_9");
    // LED, host-only pages and unmapped pages
    add_op(k_wb_wr, addr_of(3, 4), rnd[6], 0, "cpu_led_wr");
    add_op(k_check, 17'(chk_led), 0, {22'd0, rnd[6][9:0]}, "led_loaded");
    add_op(k_wb_wr, addr_of(5, 0), 1, 0, "cpu_sys_hold_wr");
    add_op(k_check, 17'(chk_hold), 0, 0, "hold_kept_cpu_wr");
    add_op(k_wb_wr, addr_of(5, 2), 0, 0, "cpu_sys_owner_wr");
    add_op(k_wb_rd, addr_of(0, 9), 0, rnd[4], "owner_kept_cpu_wr");
    add_op(k_wb_wr, addr_of(7, 4), rnd[7], 0, "cpu_unmapped_wr");
    add_op(k_wb_wr, addr_of(3, 5), rnd[7], 0, "cpu_io_other_idx_wr");
    add_op(k_check, 17'(chk_led), 0, {22'd0, rnd[6][9:0]}, "led_kept");
    // offset 9 holds a nonzero data word at this point
    add_op(k_wb_rd, addr_of(2, 9), 0, 0, "io_read_page");
    add_op(k_wb_rd, addr_of(9, 9), 0, 0, "unmapped_read");

    cycle_limit = 20;
    for (i = 0; i < n_ops; i++)
      cycle_limit = cycle_limit + 20 * cycles_of(op_kind[i]);

    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    step();

    for (i = 0; i < n_ops; i++)
    begin
      run_op(i, got, status);
      if (status == 0)
      begin
        n_pass++;
        $display("ok   %s", op_name[i]);
      end
      else if (status == 1)
      begin
        n_fail++;
        $display("Fail %s: expected %h, actual %h", op_name[i], op_exp[i], got);
      end
      else
      begin
        n_fail++;
        $display("%s: %s", op_name[i], problem_text(status));
      end
    end

    $display("tests %0d, passed %0d, failed %0d", n_ops, n_pass, n_fail);
    if (n_fail == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
